//--- bench/mgmt_patterns.txt
# Columns: operation, address (hex), value (hex) or M for a byte computed by the model
# W writes the value, R reads and expects it, H reads a serial byte with serial_valid held low
R 0010 M
R 0011 M
R 0016 M
R 001b M
R 0000 M
R 0001 M
R 0003 M
H 0006 M
R 0004 M
R 000b M
W 0048 34
W 0049 12
W 004a a7
W 004b 22
R 0048 M
R 0049 M
R 004a 00
R 004b M
W 004e 5c
W 004f 41
R 004f M
W 0050 e9
W 0053 23
R 0051 M
W 4000 5a
W 4001 f3
W 4002 13
W 4402 ff
R 4000 5a
R 4001 03
R 4002 13
R 4402 13
W 7c00 77
R 7c00 00
R 4800 00
R 0030 00

//--- bench/tb_mgmt_checks.svh
// Returned byte of the read that is finishing
task automatic check_rd_data(input logic [7:0] exp);
	if (rd_data !== exp)
		stop_on_error($sformatf("MISMATCH at %0.2f ns: read of %h returned %h, expected %h",
			$realtime, rd.addr, rd_data, exp));
endtask

// One port's configuration word
task automatic check_port_cfg(input int idx, input mgmt_dev_pkg::port_cfg_t exp);
	if (port_cfg[idx] !== exp)
		stop_on_error($sformatf("MISMATCH at %0.2f ns: port_cfg[%0d] is %h, expected %h",
			$realtime, idx, port_cfg[idx], exp));
endtask

// One MDIO channel command including the strobes
task automatic check_mdio_cmd(input int idx, input mgmt_dev_pkg::mdio_cmd_t exp);
	if (mdio_cmd[idx] !== exp)
		stop_on_error($sformatf("MISMATCH at %0.2f ns: mdio_cmd[%0d] is %h, expected %h",
			$realtime, idx, mdio_cmd[idx], exp));
endtask

//--- bench/tb_mgmt_regs.sv
`timescale 1ns/10ps

module tb_mgmt_regs;

	localparam int NUM_PORTS    = 15;
	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 5;
	// Cycles a serial read waits with serial_valid low
	localparam int HOLD_CYCLES  = 8;

	localparam logic [15:0] MDIO_BASE [3] = '{
		mgmt_bus_pkg::MDIO_MGMT0_BASE,
		mgmt_bus_pkg::MDIO_DP_BASE,
		mgmt_bus_pkg::MDIO_VSC_BASE
	};

	logic                                       clk = 1'b0;
	logic                                       arst_n;
	mgmt_bus_pkg::mgmt_rd_req_t                 rd;
	mgmt_bus_pkg::mgmt_wr_t                     wr;
	logic                                       rd_valid;
	logic [7:0]                                 rd_data;
	mgmt_dev_pkg::dev_info_t                    dev_info;
	mgmt_dev_pkg::sensors_t                     sensors;
	mgmt_dev_pkg::mdio_status_t [2:0]           mdio_status;
	mgmt_dev_pkg::mdio_cmd_t    [2:0]           mdio_cmd;
	mgmt_dev_pkg::port_cfg_t [NUM_PORTS-1:0]    port_cfg;

	// Reference model state
	mgmt_dev_pkg::port_cfg_t  exp_port [NUM_PORTS];
	mgmt_dev_pkg::mdio_cmd_t  exp_mdio [3];

	// Pattern lines
	string       op_q [$];
	logic [15:0] addr_q [$];
	logic [7:0]  val_q [$];
	bit          model_q [$];
	bit          loaded = 1'b0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	mgmt_register_interface #(
		.NUM_PORTS (NUM_PORTS)
	) i_mgmt_register_interface (
		.clk         (clk),
		.arst_n      (arst_n),
		.rd          (rd),
		.wr          (wr),
		.rd_valid    (rd_valid),
		.rd_data     (rd_data),
		.dev_info    (dev_info),
		.sensors     (sensors),
		.mdio_status (mdio_status),
		.mdio_cmd    (mdio_cmd),
		.port_cfg    (port_cfg)
	);

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	`include "tb_mgmt_checks.svh"

	//////////////////////////////////////////////////
	// Reference model

	// Byte a read should return for the randomized inputs
	function automatic logic [7:0] expected_byte(input logic [15:0] addr);
		int          off;
		logic [15:0] word;
		if (addr < 16'h0004)
			return 8'(dev_info.idcode >> (8 * (3 - int'(addr))));
		if (addr >= 16'h0004 && addr < 16'h000c)
			return 8'(dev_info.serial >> (8 * (11 - int'(addr))));
		if (addr >= 16'h0010 && addr < 16'h001c) begin
			off = int'(addr) - 16;
			case (off / 2)
				0:       word = sensors.fan0_rpm;
				1:       word = sensors.fan1_rpm;
				2:       word = sensors.die_temp;
				3:       word = sensors.volt_core;
				4:       word = sensors.volt_ram;
				default: word = sensors.volt_aux;
			endcase
			return (off % 2 == 1) ? word[15:8] : word[7:0];
		end
		for (int c = 0; c < 3; c++) begin
			off = int'(addr) - int'(MDIO_BASE[c]);
			if (off == 0) return mdio_status[c].rd_data[7:0];
			if (off == 1) return mdio_status[c].rd_data[15:8];
			if (off == 3) return {mdio_status[c].busy, 7'b0};
		end
		return 8'h00;
	endfunction

	// Expected effect of one write including strobes
	function automatic void update_model(input logic [15:0] addr, input logic [7:0] data);
		int rel;
		int off;
		int p;
		rel = int'(addr) - int'(mgmt_bus_pkg::PORT_BASE);
		p   = rel / 1024;
		if (rel >= 0 && p < NUM_PORTS) begin
			case (rel % 1024)
				0: exp_port[p].vlan[7:0]  = data;
				1: exp_port[p].vlan[11:8] = data[3:0];
				2: begin
					exp_port[p].tagged_allowed   = data[0];
					exp_port[p].untagged_allowed = data[1];
					exp_port[p].is_trunk         = data[4];
				end
				default: ;
			endcase
		end
		for (int c = 0; c < 3; c++) begin
			off = int'(addr) - int'(MDIO_BASE[c]);
			case (off)
				0: exp_mdio[c].wr_data[7:0]  = data;
				1: exp_mdio[c].wr_data[15:8] = data;
				2: begin
					exp_mdio[c].reg_addr      = data[4:0];
					exp_mdio[c].phy_addr[2:0] = data[7:5];
				end
				3: begin
					exp_mdio[c].phy_addr[4:3] = data[1:0];
					exp_mdio[c].rd            = data[5];
					exp_mdio[c].wr            = data[6];
				end
				default: ;
			endcase
		end
	endfunction

	task automatic check_outputs();
		for (int p = 0; p < NUM_PORTS; p++)
			check_port_cfg(p, exp_port[p]);
		for (int c = 0; c < 3; c++)
			check_mdio_cmd(c, exp_mdio[c]);
	endtask

	//////////////////////////////////////////////////
	// Host bus operations

	task automatic write_byte(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		wr <= {1'b1, addr, data};
		@(posedge clk);
		wr.en <= 1'b0;
		update_model(addr, data);
		@(negedge clk);
		check_outputs();
		// Strobes must be gone one cycle later
		for (int c = 0; c < 3; c++) begin
			exp_mdio[c].rd = 1'b0;
			exp_mdio[c].wr = 1'b0;
		end
		@(negedge clk);
		check_outputs();
	endtask

	task automatic read_byte(input logic [15:0] addr, input logic [7:0] exp, input bit hold);
		int wait_cycles;
		@(posedge clk);
		rd <= {1'b1, addr};
		@(posedge clk);
		rd.en <= 1'b0;
		if (hold) begin
			repeat (HOLD_CYCLES) begin
				@(negedge clk);
				if (rd_valid)
					stop_on_error($sformatf("MISMATCH at %0.2f ns: rd_valid while serial_valid low",
						$realtime));
			end
			@(posedge clk);
			dev_info.serial_valid <= 1'b1;
		end
		@(negedge clk);
		wait_cycles = 1;
		while (!rd_valid) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (!hold && wait_cycles != 1)
			stop_on_error($sformatf("MISMATCH at %0.2f ns: read of %h took %0d cycles",
				$realtime, addr, wait_cycles));
		check_rd_data(exp);
		@(negedge clk);
		if (rd_valid)
			stop_on_error($sformatf("MISMATCH at %0.2f ns: rd_valid longer than one cycle",
				$realtime));
	endtask

	task automatic load_patterns();
		int          fd;
		string       line;
		string       op;
		string       tok;
		logic [15:0] addr;
		logic [7:0]  val;
		fd = $fopen("bench/mgmt_patterns.txt", "r");
		if (fd == 0)
			stop_on_error("The pattern file bench/mgmt_patterns.txt could not be opened");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// Skip blank and comment lines
			if (line.len() < 3 || line[0] == "#")
				continue;
			if ($sscanf(line, "%s %h %s", op, addr, tok) != 3)
				stop_on_error($sformatf("A pattern line could not be parsed: %s", line));
			val = 8'h00;
			if (tok != "M")
				void'($sscanf(tok, "%h", val));
			op_q.push_back(op);
			addr_q.push_back(addr);
			val_q.push_back(val);
			model_q.push_back(tok == "M");
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		void'($urandom(32'h252e));
		arst_n      <= 1'b0;
		rd          <= '0;
		wr          <= '0;
		// Random device data with idcode valid and serial not yet valid
		dev_info    <= {$urandom, 1'b1, $urandom, $urandom, 1'b0};
		sensors     <= {$urandom, $urandom, $urandom};
		for (int c = 0; c < 3; c++)
			mdio_status[c] <= 17'($urandom);
		for (int p = 0; p < NUM_PORTS; p++)
			exp_port[p] = '0;
		for (int c = 0; c < 3; c++)
			exp_mdio[c] = '0;
		load_patterns();
		loaded = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		if (rd_valid !== 1'b0)
			stop_on_error($sformatf("MISMATCH at %0.2f ns: rd_valid set after reset", $realtime));
		check_outputs();

		foreach (op_q[i]) begin
			if (op_q[i] == "W")
				write_byte(addr_q[i], val_q[i]);
			else if (op_q[i] == "R" || op_q[i] == "H")
				read_byte(addr_q[i], model_q[i] ? expected_byte(addr_q[i]) : val_q[i],
					op_q[i] == "H");
			else
				stop_on_error($sformatf("Unknown operation %s in the pattern file", op_q[i]));
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

	// Watchdog sized from the pattern count
	initial begin
		wait (loaded);
		#(CLK_PERIOD * (RESET_CYCLES + 30 * op_q.size() + HOLD_CYCLES));
		$display("Timeout: the run did not finish in the time allowed for %0d pattern lines",
			op_q.size());
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- list.f
+incdir+bench
source/mgmt_bus_pkg.sv
source/mgmt_dev_pkg.sv
source/info_sensor_regs.sv
source/mdio_channel_regs.sv
source/port_config_regs.sv
source/read_return.sv
source/mgmt_register_interface.sv
bench/tb_mgmt_regs.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module tb_mgmt_regs -o tb_sim
./obj_dir/tb_sim

//--- source/info_sensor_regs.sv
`timescale 1ns/10ps

module info_sensor_regs (
	input  mgmt_bus_pkg::mgmt_rd_req_t rd,
	input  mgmt_dev_pkg::dev_info_t    dev_info,
	input  mgmt_dev_pkg::sensors_t     sensors,
	output mgmt_bus_pkg::rd_result_t   result
);

	//////////////////////////////////////////////////
	// Address decode

	// Offsets from each base where a wrap below the base keeps them out of range
	logic [15:0] id_off;
	logic [15:0] ser_off;
	logic [15:0] sen_off;
	logic        id_hit;
	logic        ser_hit;
	logic        sen_hit;

	assign id_off  = rd.addr - mgmt_bus_pkg::IDCODE_BASE;
	assign ser_off = rd.addr - mgmt_bus_pkg::SERIAL_BASE;
	assign sen_off = rd.addr - mgmt_bus_pkg::SENSOR_BASE;

	// 4 bytes IDCODE, 8 bytes serial, six 16-bit sensors
	assign id_hit  = id_off < 16'd4;
	assign ser_hit = ser_off < 16'd8;
	assign sen_hit = sen_off < 16'd12;

	//////////////////////////////////////////////////
	// Byte select

	// Sensor words in register order
	logic [15:0] sensor_word [6];
	logic [15:0] sel_word;

	assign sensor_word[0] = sensors.fan0_rpm;
	assign sensor_word[1] = sensors.fan1_rpm;
	assign sensor_word[2] = sensors.die_temp;
	assign sensor_word[3] = sensors.volt_core;
	assign sensor_word[4] = sensors.volt_ram;
	assign sensor_word[5] = sensors.volt_aux;

	// Index bounded by sen_hit
	assign sel_word = sensor_word[sen_off[3:1]];

	always_comb begin
		result.hit   = id_hit || ser_hit || sen_hit;
		result.ready = 1'b1;
		result.data  = '0;

		if (id_hit) begin
			// MSB first so offset 0 is idcode[31:24]
			result.data  = dev_info.idcode[{~id_off[1:0], 3'b000} +: 8];
			result.ready = dev_info.idcode_valid;
		end
		else if (ser_hit) begin
			// Same ordering for the die serial
			result.data  = dev_info.serial[{~ser_off[2:0], 3'b000} +: 8];
			result.ready = dev_info.serial_valid;
		end
		else if (sen_hit) begin
			// Little endian with the low byte at even offset
			result.data = sen_off[0] ? sel_word[15:8] : sel_word[7:0];
		end
	end

endmodule

//--- source/mdio_channel_regs.sv
`timescale 1ns/10ps

module mdio_channel_regs #(
	parameter logic [15:0] BASE = mgmt_bus_pkg::MDIO_MGMT0_BASE
) (
	input  logic                         clk,
	input  logic                         arst_n,
	input  mgmt_bus_pkg::mgmt_rd_req_t   rd,
	input  mgmt_bus_pkg::mgmt_wr_t       wr,
	input  mgmt_dev_pkg::mdio_status_t   status,
	output mgmt_dev_pkg::mdio_cmd_t      cmd,
	output mgmt_bus_pkg::rd_result_t     result
);

	// Four byte window per channel
	logic [15:0] rd_off;
	logic [15:0] wr_off;
	logic        rd_hit;
	logic        wr_hit;

	assign rd_off = rd.addr - BASE;
	assign wr_off = wr.addr - BASE;
	assign rd_hit = rd_off < 16'd4;
	assign wr_hit = wr.en && (wr_off < 16'd4);

	//////////////////////////////////////////////////
	// Command fields and strobes

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cmd <= '0;
		end
		else begin
			// Strobes last one cycle
			cmd.rd <= 1'b0;
			cmd.wr <= 1'b0;

			if (wr_hit) begin
				case (wr_off[1:0])
					2'd0: cmd.wr_data[7:0]  <= wr.data;
					2'd1: cmd.wr_data[15:8] <= wr.data;
					2'd2: begin
						cmd.reg_addr      <= wr.data[4:0];
						cmd.phy_addr[2:0] <= wr.data[7:5];
					end
					default: begin
						// Top PHY address bits plus the kick
						cmd.phy_addr[4:3] <= wr.data[1:0];
						cmd.rd            <= wr.data[5];
						cmd.wr            <= wr.data[6];
					end
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// Readback

	always_comb begin
		result.hit   = rd_hit;
		result.ready = 1'b1;
		case (rd_off[1:0])
			2'd0:    result.data = status.rd_data[7:0];
			2'd1:    result.data = status.rd_data[15:8];
			2'd2:    result.data = '0;
			default: result.data = {status.busy, 7'b0};
		endcase
	end

	// Host must not ask for a read and a write in one kick
	a_single_strobe: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(cmd.rd && cmd.wr)
	);

endmodule

//--- source/mgmt_bus_pkg.sv
package mgmt_bus_pkg;

	//////////////////////////////////////////////////
	// Bus payloads

	// Read request with the address held until rd_valid
	typedef struct packed {
		logic        en;
		logic [15:0] addr;
	} mgmt_rd_req_t;

	// Single cycle write
	typedef struct packed {
		logic        en;
		logic [15:0] addr;
		logic [7:0]  data;
	} mgmt_wr_t;

	// Combinational answer from one register block
	typedef struct packed {
		logic       hit;
		logic       ready;
		logic [7:0] data;
	} rd_result_t;

	//////////////////////////////////////////////////
	// Register map

	localparam logic [15:0] IDCODE_BASE     = 16'h0000;
	localparam logic [15:0] SERIAL_BASE     = 16'h0004;
	localparam logic [15:0] SENSOR_BASE     = 16'h0010;
	localparam logic [15:0] MDIO_MGMT0_BASE = 16'h0048;
	localparam logic [15:0] MDIO_DP_BASE    = 16'h004c;
	localparam logic [15:0] MDIO_VSC_BASE   = 16'h0050;
	localparam logic [15:0] PORT_BASE       = 16'h4000;

	// Address space given to each port
	localparam logic [15:0] PORT_STRIDE = 16'h0400;

	// Port address split into port number and register ID
	localparam int PORT_BITS  = 4;
	localparam int REGID_BITS = 10;

	// Offsets inside one port window
	localparam logic [REGID_BITS-1:0] VLAN_LO  = 10'd0;
	localparam logic [REGID_BITS-1:0] VLAN_HI  = 10'd1;
	localparam logic [REGID_BITS-1:0] TAG_MODE = 10'd2;

endpackage

//--- source/mgmt_dev_pkg.sv
package mgmt_dev_pkg;

	// 802.1Q VLAN ID
	typedef logic [11:0] vlan_t;

	// Per-port switching configuration
	typedef struct packed {
		vlan_t vlan;
		logic  tagged_allowed;
		logic  untagged_allowed;
		logic  is_trunk;
	} port_cfg_t;

	// Command towards one MDIO controller
	// rd and wr are single cycle strobes
	typedef struct packed {
		logic [4:0]  phy_addr;
		logic [4:0]  reg_addr;
		logic [15:0] wr_data;
		logic        rd;
		logic        wr;
	} mdio_cmd_t;

	// Status back from one MDIO controller
	typedef struct packed {
		logic        busy;
		logic [15:0] rd_data;
	} mdio_status_t;

	// Die identification whose valid flags rise some time after config
	typedef struct packed {
		logic [31:0] idcode;
		logic        idcode_valid;
		logic [63:0] serial;
		logic        serial_valid;
	} dev_info_t;

	// Board and die sensor values
	typedef struct packed {
		logic [15:0] fan0_rpm;
		logic [15:0] fan1_rpm;
		logic [15:0] die_temp;
		logic [15:0] volt_core;
		logic [15:0] volt_ram;
		logic [15:0] volt_aux;
	} sensors_t;

endpackage

//--- source/mgmt_register_interface.sv
`timescale 1ns/10ps

module mgmt_register_interface #(
	parameter int NUM_PORTS = 15
) (
	input  logic                                       clk,
	input  logic                                       arst_n,

	// Host bus
	input  mgmt_bus_pkg::mgmt_rd_req_t                 rd,
	input  mgmt_bus_pkg::mgmt_wr_t                     wr,
	output logic                                       rd_valid,
	output logic [7:0]                                 rd_data,

	// Device info and sensors
	input  mgmt_dev_pkg::dev_info_t                    dev_info,
	input  mgmt_dev_pkg::sensors_t                     sensors,

	// MDIO channels in mgmt0 then data plane then switch chip order
	input  mgmt_dev_pkg::mdio_status_t [2:0]           mdio_status,
	output mgmt_dev_pkg::mdio_cmd_t    [2:0]           mdio_cmd,

	// Port configuration in the core domain
	output mgmt_dev_pkg::port_cfg_t [NUM_PORTS-1:0]    port_cfg
);

	// Channel base addresses by index
	localparam logic [15:0] MDIO_BASES [3] = '{
		mgmt_bus_pkg::MDIO_MGMT0_BASE,
		mgmt_bus_pkg::MDIO_DP_BASE,
		mgmt_bus_pkg::MDIO_VSC_BASE
	};

	mgmt_bus_pkg::rd_result_t       info_res;
	mgmt_bus_pkg::rd_result_t       port_res;
	mgmt_bus_pkg::rd_result_t [2:0] mdio_res;

	//////////////////////////////////////////////////
	// Register blocks

	info_sensor_regs i_info_sensor_regs (
		.rd       (rd),
		.dev_info (dev_info),
		.sensors  (sensors),
		.result   (info_res)
	);

	for (genvar g = 0; g < 3; g++) begin : g_mdio
		mdio_channel_regs #(
			.BASE (MDIO_BASES[g])
		) i_mdio_channel_regs (
			.clk    (clk),
			.arst_n (arst_n),
			.rd     (rd),
			.wr     (wr),
			.status (mdio_status[g]),
			.cmd    (mdio_cmd[g]),
			.result (mdio_res[g])
		);
	end

	port_config_regs #(
		.NUM_PORTS (NUM_PORTS)
	) i_port_config_regs (
		.clk      (clk),
		.arst_n   (arst_n),
		.rd       (rd),
		.wr       (wr),
		.port_cfg (port_cfg),
		.result   (port_res)
	);

	//////////////////////////////////////////////////
	// Read return path

	read_return i_read_return (
		.clk      (clk),
		.arst_n   (arst_n),
		.rd       (rd),
		.info     (info_res),
		.port     (port_res),
		.mdio     (mdio_res),
		.rd_valid (rd_valid),
		.rd_data  (rd_data)
	);

endmodule

//--- source/port_config_regs.sv
`timescale 1ns/10ps

module port_config_regs #(
	parameter int NUM_PORTS = 15
) (
	input  logic                                     clk,
	input  logic                                     arst_n,
	input  mgmt_bus_pkg::mgmt_rd_req_t               rd,
	input  mgmt_bus_pkg::mgmt_wr_t                   wr,
	output mgmt_dev_pkg::port_cfg_t [NUM_PORTS-1:0]  port_cfg,
	output mgmt_bus_pkg::rd_result_t                 result
);

	// Bytes of address space taken by the configured ports
	localparam logic [31:0] WINDOW = NUM_PORTS * mgmt_bus_pkg::PORT_STRIDE;

	//////////////////////////////////////////////////
	// Address split

	logic [15:0]                         rd_rel;
	logic [15:0]                         wr_rel;
	logic [mgmt_bus_pkg::PORT_BITS-1:0]  rd_port;
	logic [mgmt_bus_pkg::PORT_BITS-1:0]  wr_port;
	logic [mgmt_bus_pkg::REGID_BITS-1:0] rd_regid;
	logic [mgmt_bus_pkg::REGID_BITS-1:0] wr_regid;
	logic                                rd_hit;
	logic                                rd_ok;
	logic                                wr_ok;
	mgmt_dev_pkg::port_cfg_t             rd_cfg;

	// Whole space above PORT_BASE belongs here
	assign rd_hit = rd.addr >= mgmt_bus_pkg::PORT_BASE;

	assign rd_rel   = rd.addr - mgmt_bus_pkg::PORT_BASE;
	assign wr_rel   = wr.addr - mgmt_bus_pkg::PORT_BASE;
	assign rd_port  = rd_rel[mgmt_bus_pkg::REGID_BITS +: mgmt_bus_pkg::PORT_BITS];
	assign wr_port  = wr_rel[mgmt_bus_pkg::REGID_BITS +: mgmt_bus_pkg::PORT_BITS];
	assign rd_regid = rd_rel[mgmt_bus_pkg::REGID_BITS-1:0];
	assign wr_regid = wr_rel[mgmt_bus_pkg::REGID_BITS-1:0];

	// Ports past NUM_PORTS fall outside the window
	assign rd_ok = rd_hit && (32'(rd_rel) < WINDOW);
	assign wr_ok = wr.en && (wr.addr >= mgmt_bus_pkg::PORT_BASE) && (32'(wr_rel) < WINDOW);

	//////////////////////////////////////////////////
	// Port storage

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			port_cfg <= '0;
		end
		else if (wr_ok) begin
			for (int i = 0; i < NUM_PORTS; i++) begin
				if (wr_port == mgmt_bus_pkg::PORT_BITS'(i)) begin
					// Little endian VLAN number
					case (wr_regid)
						mgmt_bus_pkg::VLAN_LO: port_cfg[i].vlan[7:0]  <= wr.data;
						mgmt_bus_pkg::VLAN_HI: port_cfg[i].vlan[11:8] <= wr.data[3:0];
						mgmt_bus_pkg::TAG_MODE: begin
							port_cfg[i].tagged_allowed   <= wr.data[0];
							port_cfg[i].untagged_allowed <= wr.data[1];
							port_cfg[i].is_trunk         <= wr.data[4];
						end
						default: ;
					endcase
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Readback

	// Selected port or zero when out of range
	always_comb begin
		rd_cfg = '0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (rd_ok && rd_port == mgmt_bus_pkg::PORT_BITS'(i))
				rd_cfg = port_cfg[i];
		end
	end

	always_comb begin
		result.hit   = rd_hit;
		result.ready = 1'b1;
		case (rd_regid)
			mgmt_bus_pkg::VLAN_LO:  result.data = rd_cfg.vlan[7:0];
			mgmt_bus_pkg::VLAN_HI:  result.data = {4'b0, rd_cfg.vlan[11:8]};
			mgmt_bus_pkg::TAG_MODE: result.data = {3'b0, rd_cfg.is_trunk, 2'b0,
				rd_cfg.untagged_allowed, rd_cfg.tagged_allowed};
			default:                result.data = '0;
		endcase
	end

endmodule

//--- source/read_return.sv
`timescale 1ns/10ps

module read_return (
	input  logic                                clk,
	input  logic                                arst_n,
	input  mgmt_bus_pkg::mgmt_rd_req_t          rd,
	input  mgmt_bus_pkg::rd_result_t            info,
	input  mgmt_bus_pkg::rd_result_t            port,
	input  mgmt_bus_pkg::rd_result_t [2:0]      mdio,
	output logic                                rd_valid,
	output logic [7:0]                          rd_data
);

	mgmt_bus_pkg::rd_result_t all_res [5];
	mgmt_bus_pkg::rd_result_t sel;
	logic [4:0]               hits;
	logic                     reading;
	logic                     active;
	logic                     done;

	assign all_res[0] = info;
	assign all_res[1] = port;
	assign all_res[2] = mdio[0];
	assign all_res[3] = mdio[1];
	assign all_res[4] = mdio[2];

	// Pick the hitting block or all zero if none
	always_comb begin
		sel = '0;
		for (int i = 0; i < 5; i++) begin
			hits[i] = all_res[i].hit;
			if (all_res[i].hit)
				sel = all_res[i];
		end
	end

	// Open read finishes once its block is ready
	// Unmapped addresses finish at once
	assign active = rd.en || reading;
	assign done   = active && (!sel.hit || sel.ready);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			reading  <= 1'b0;
			rd_valid <= 1'b0;
		end
		else begin
			rd_valid <= done;
			if (done)
				reading <= 1'b0;
			else if (rd.en)
				reading <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rd_data <= '0;
		else if (done)
			rd_data <= sel.data;
	end

	//////////////////////////////////////////////////
	// Protocol checks

	a_no_overlap: assert property (
		@(posedge clk) disable iff (!arst_n)
		rd.en |-> !reading
	);

	a_one_hit: assert property (
		@(posedge clk) disable iff (!arst_n)
		active |-> $onehot0(hits)
	);

endmodule
